// File: source/dma_pkg.sv
// one tile id and four slots fixed here; l2r sizes must be nonzero and fit in size_w bits
`default_nettype none

package dma_pkg;

   // table geometry
   localparam int table_entries = 4;
   localparam int table_ptr_w = 2;

   // this tile on the noc
   localparam logic [4:0] tile_id = 5'd3;

   // header and address flit take two slots of every packet
   localparam int packet_flits = 8;
   localparam int size_w = 12;

   localparam logic [2:0] class_dma = 3'd2;

   typedef logic [table_ptr_w-1:0] slot_t;
   typedef logic [size_w-1:0] size_t;

   // payload words per full packet
   localparam size_t pkt_words = size_t'(packet_flits - 2);

   // flit type on the wire
   typedef enum logic [1:0] {
      payload = 2'b00,
      header  = 2'b01,
      last    = 2'b10
   } flit_type_e;

   typedef enum logic {
      l2r = 1'b0,
      r2l = 1'b1
   } dma_dir_e;

   // packet type inside the header
   typedef enum logic [1:0] {
      l2r_req = 2'b00,
      r2l_req = 2'b01
   } pkt_type_e;

   // request generator states
   typedef enum logic [2:0] {
      idle,
      l2r_hdr,
      l2r_addr,
      l2r_data,
      r2l_hdr,
      r2l_size,
      r2l_raddr,
      r2l_laddr
   } req_state_e;

   // one transfer descriptor
   typedef struct packed {
      dma_dir_e    dir;
      logic [4:0]  rtile;
      size_t       size;
      logic [31:0] laddr;
      logic [31:0] raddr;
   } dma_req_t;

   typedef struct packed {
      flit_type_e  ftype;
      logic [31:0] content;
   } noc_flit_t;

   // overlay on the content of a header flit, msb first
   typedef struct packed {
      logic [4:0] dest;
      logic [2:0] pclass;
      logic [4:0] src;
      pkt_type_e  ptype;
      slot_t      id;
      logic       last;
      logic [1:0] rsvd;
      size_t      size;
   } noc_hdr_t;

endpackage

`default_nettype wire

// File: source/dma_req_table.sv
// a write and a done to the same slot in one cycle is not supported; read port is combinational
`default_nettype none

module dma_req_table (
   input  wire logic                clk,
   input  wire logic                rst,

   // control side writes
   input  wire logic                ctrl_wr_en,
   input  wire dma_pkg::slot_t      ctrl_wr_pos,
   input  wire dma_pkg::dma_req_t   ctrl_wr_req,

   // response side completion
   input  wire logic                ctrl_done_en,
   input  wire dma_pkg::slot_t      ctrl_done_pos,

   // generator read port
   input  wire dma_pkg::slot_t      read_pos,
   output dma_pkg::dma_req_t        read_req,
   output logic [dma_pkg::table_entries-1:0] valid
);

   // descriptor storage
   dma_pkg::dma_req_t entries [dma_pkg::table_entries];

   // descriptor payload
   always_ff @(posedge clk) begin
      if (ctrl_wr_en) begin
         entries[ctrl_wr_pos] <= ctrl_wr_req;
      end
   end

   // valid bits
   // set on write, cleared when the response path reports done
   always_ff @(posedge clk) begin
      if (rst) begin
         valid <= '0;
      end else begin
         if (ctrl_wr_en) begin
            valid[ctrl_wr_pos] <= 1'b1;
         end
         if (ctrl_done_en) begin
            valid[ctrl_done_pos] <= 1'b0;
         end
      end
   end

   // selected slot straight to the generator
   assign read_req = entries[read_pos];

endmodule

`default_nettype wire

// File: source/dma_rr_arb.sv
// gnt must be one-hot or zero; zero behaves like a grant on slot 0
`default_nettype none

module dma_rr_arb (
   input  wire logic [dma_pkg::table_entries-1:0] req,
   input  wire logic [dma_pkg::table_entries-1:0] gnt,
   output logic [dma_pkg::table_entries-1:0]      nxt_gnt
);

   always_comb begin : search
      int cur;
      int idx;
      logic hit;

      // index of current grant
      cur = 0;
      for (int d = 0; d < dma_pkg::table_entries; d++) begin
         if (gnt[d]) begin
            cur = d;
         end
      end

      // walk upward from the slot after cur, wrapping round
      // i == table_entries lands on cur itself
      hit = 1'b0;
      nxt_gnt = gnt;
      for (int i = 1; i <= dma_pkg::table_entries; i++) begin
         idx = (cur + i) % dma_pkg::table_entries;
         if (!hit && req[idx]) begin
            nxt_gnt = '0;
            nxt_gnt[idx] = 1'b1;
            hit = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/dma_noc_req_gen.sv
// no flow control on req_start; l2r flits hold only while word_valid stays high
`default_nettype none

module dma_noc_req_gen (
   input  wire logic                                clk,
   input  wire logic                                rst,

   // table side
   input  wire logic [dma_pkg::table_entries-1:0]   valid,
   input  wire logic                                ctrl_done_en,
   input  wire dma_pkg::slot_t                      ctrl_done_pos,
   output dma_pkg::slot_t                           read_pos,
   input  wire dma_pkg::dma_req_t                   read_req,

   // local reader side
   output logic                                     req_start,
   input  wire logic                                word_valid,
   input  wire logic [31:0]                         word,
   output logic                                     word_ready,

   // noc flit port
   output logic                                     noc_out_valid,
   output dma_pkg::noc_flit_t                       noc_out,
   input  wire logic                                noc_out_ready
);

   dma_pkg::req_state_e state, nxt_state;

   // words sent in earlier packets of this request
   dma_pkg::size_t counter, nxt_counter;
   // position inside current packet, starts at 1
   dma_pkg::size_t pkt_count, nxt_pkt_count;
   dma_pkg::size_t pkt_size, nxt_pkt_size;

   logic [dma_pkg::table_entries-1:0] select, nxt_select;
   logic [dma_pkg::table_entries-1:0] open_resp, nxt_open_resp;
   logic [dma_pkg::table_entries-1:0] requests;
   logic nxt_req_start;

   dma_pkg::noc_hdr_t hdr;
   dma_pkg::size_t    remain;

   // eligible slots, only looked at while idle
   assign requests = valid & ~open_resp & {dma_pkg::table_entries{state == dma_pkg::idle}};

   // single cycle start, suppressed while the previous pulse is out
   assign nxt_req_start = (|requests) & ~req_start;

   dma_rr_arb u_arb (
      .req     (requests),
      .gnt     (select),
      .nxt_gnt (nxt_select)
   );

   // one-hot select to slot index
   always_comb begin
      read_pos = '0;
      for (int d = 0; d < dma_pkg::table_entries; d++) begin
         if (select[d]) begin
            read_pos = dma_pkg::slot_t'(d);
         end
      end
   end

   // words still to go for the current request
   assign remain = read_req.size - counter;

   // header fields common to both directions
   always_comb begin
      hdr        = '0;
      hdr.dest   = read_req.rtile;
      hdr.pclass = dma_pkg::class_dma;
      hdr.src    = dma_pkg::tile_id;
      hdr.id     = read_pos;
      if (state == dma_pkg::l2r_hdr) begin
         hdr.ptype = dma_pkg::l2r_req;
         // full packet unless the tail fits
         if (remain > dma_pkg::pkt_words) begin
            hdr.size = dma_pkg::pkt_words;
            hdr.last = 1'b0;
         end else begin
            hdr.size = remain;
            hdr.last = 1'b1;
         end
      end else begin
         // r2l is always one packet with empty size
         hdr.ptype = dma_pkg::r2l_req;
         hdr.last  = 1'b1;
      end
   end

   always_comb begin
      nxt_state      = state;
      nxt_counter    = counter;
      nxt_pkt_count  = pkt_count;
      nxt_pkt_size   = pkt_size;
      nxt_open_resp  = open_resp;
      noc_out_valid  = 1'b0;
      noc_out.ftype  = dma_pkg::payload;
      noc_out.content = '0;
      word_ready     = 1'b0;

      case (state)
         dma_pkg::idle: begin
            nxt_counter = '0;
            if (req_start) begin
               if (read_req.dir == dma_pkg::l2r) begin
                  nxt_state = dma_pkg::l2r_hdr;
               end else begin
                  nxt_state = dma_pkg::r2l_hdr;
               end
            end
         end
         dma_pkg::l2r_hdr: begin
            noc_out_valid   = 1'b1;
            noc_out.ftype   = dma_pkg::header;
            noc_out.content = hdr;
            if (noc_out_ready) begin
               nxt_pkt_size  = hdr.size;
               nxt_pkt_count = dma_pkg::size_t'(1);
               nxt_state     = dma_pkg::l2r_addr;
            end
         end
         dma_pkg::l2r_addr: begin
            // remote byte address advances by the words already sent
            noc_out_valid   = 1'b1;
            noc_out.content = read_req.raddr + 32'({counter, 2'b00});
            if (noc_out_ready) begin
               nxt_state = dma_pkg::l2r_data;
            end
         end
         dma_pkg::l2r_data: begin
            noc_out_valid   = word_valid;
            noc_out.content = word;
            if (pkt_count == pkt_size) begin
               noc_out.ftype = dma_pkg::last;
            end
            if (word_valid && noc_out_ready) begin
               word_ready    = 1'b1;
               nxt_pkt_count = pkt_count + 1'b1;
               if (pkt_count == pkt_size) begin
                  if (counter + pkt_count == read_req.size) begin
                     // whole request out, wait for done
                     nxt_open_resp = open_resp | select;
                     nxt_state     = dma_pkg::idle;
                  end else begin
                     nxt_counter = counter + pkt_count;
                     nxt_state   = dma_pkg::l2r_hdr;
                  end
               end
            end
         end
         dma_pkg::r2l_hdr: begin
            noc_out_valid   = 1'b1;
            noc_out.ftype   = dma_pkg::header;
            noc_out.content = hdr;
            if (noc_out_ready) begin
               nxt_state = dma_pkg::r2l_size;
            end
         end
         dma_pkg::r2l_size: begin
            noc_out_valid   = 1'b1;
            noc_out.content = 32'(read_req.size);
            if (noc_out_ready) begin
               nxt_state = dma_pkg::r2l_raddr;
            end
         end
         dma_pkg::r2l_raddr: begin
            noc_out_valid   = 1'b1;
            noc_out.content = read_req.raddr;
            if (noc_out_ready) begin
               nxt_state = dma_pkg::r2l_laddr;
            end
         end
         dma_pkg::r2l_laddr: begin
            noc_out_valid   = 1'b1;
            noc_out.ftype   = dma_pkg::last;
            noc_out.content = read_req.laddr;
            if (noc_out_ready) begin
               nxt_open_resp = open_resp | select;
               nxt_state     = dma_pkg::idle;
            end
         end
         default: begin
            nxt_state = dma_pkg::idle;
         end
      endcase

      // response path releases the slot
      if (ctrl_done_en) begin
         nxt_open_resp[ctrl_done_pos] = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= dma_pkg::idle;
         counter   <= '0;
         pkt_count <= '0;
         pkt_size  <= '0;
         open_resp <= '0;
         req_start <= 1'b0;
         // next search begins at slot 1
         select    <= dma_pkg::table_entries'(1);
      end else begin
         state     <= nxt_state;
         counter   <= nxt_counter;
         pkt_count <= nxt_pkt_count;
         pkt_size  <= nxt_pkt_size;
         open_resp <= nxt_open_resp;
         req_start <= nxt_req_start;
         // grant moves together with the start pulse
         if (nxt_req_start) begin
            select <= nxt_select;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/dma_local_reader.sv
// one bus read outstanding at a time; a new l2r start is expected only once the buffer is drained
`default_nettype none

module dma_local_reader (
   input  wire logic              clk,
   input  wire logic              rst,

   // start from the generator
   input  wire logic              req_start,
   input  wire dma_pkg::dma_req_t read_req,

   // local bus
   output logic                   lbus_req,
   output logic [31:0]            lbus_addr,
   input  wire logic              lbus_ack,
   input  wire logic [31:0]       lbus_data,

   // word stream to the generator
   output logic                   word_valid,
   output logic [31:0]            word,
   input  wire logic              word_ready
);

   // two entry buffer
   logic [31:0] buf_mem [2];
   logic        wr_ptr;
   logic        rd_ptr;
   logic [1:0]  fill, nxt_fill;

   dma_pkg::size_t remain, nxt_remain;
   logic start_l2r;
   logic push;
   logic pop;

   assign start_l2r = req_start && (read_req.dir == dma_pkg::l2r);
   assign push      = lbus_req && lbus_ack;
   assign pop       = word_valid && word_ready;

   assign word_valid = (fill != 2'd0);
   assign word       = buf_mem[rd_ptr];

   always_comb begin
      nxt_fill = fill;
      if (push && !pop) begin
         nxt_fill = fill + 2'd1;
      end else if (pop && !push) begin
         nxt_fill = fill - 2'd1;
      end
   end

   always_comb begin
      nxt_remain = remain;
      if (start_l2r) begin
         nxt_remain = read_req.size;
      end else if (push) begin
         nxt_remain = remain - 1'b1;
      end
   end

   // bus data lands in the buffer
   always_ff @(posedge clk) begin
      if (push) begin
         buf_mem[wr_ptr] <= lbus_data;
      end
      if (start_l2r) begin
         lbus_addr <= read_req.laddr;
      end else if (push) begin
         lbus_addr <= lbus_addr + 32'd4;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         lbus_req <= 1'b0;
         remain   <= '0;
         fill     <= 2'd0;
         wr_ptr   <= 1'b0;
         rd_ptr   <= 1'b0;
      end else begin
         remain <= nxt_remain;
         fill   <= nxt_fill;
         if (push) begin
            wr_ptr <= ~wr_ptr;
         end
         if (pop) begin
            rd_ptr <= ~rd_ptr;
         end
         // hold until ack, then ask again only with room and words left
         if (lbus_req && !lbus_ack) begin
            lbus_req <= 1'b1;
         end else begin
            lbus_req <= (nxt_remain != '0) && (nxt_fill != 2'd2);
         end
      end
   end

endmodule

`default_nettype wire

// File: source/dma_initiator_top.sv
// request side only; the response path must pulse ctrl_done_en to release a slot
`default_nettype none

module dma_initiator_top (
   input  wire logic              clk,
   input  wire logic              rst,

   input  wire logic              ctrl_wr_en,
   input  wire dma_pkg::slot_t    ctrl_wr_pos,
   input  wire dma_pkg::dma_req_t ctrl_wr_req,
   input  wire logic              ctrl_done_en,
   input  wire dma_pkg::slot_t    ctrl_done_pos,

   output logic                   lbus_req,
   output logic [31:0]            lbus_addr,
   input  wire logic              lbus_ack,
   input  wire logic [31:0]       lbus_data,

   output logic                   noc_out_valid,
   output dma_pkg::noc_flit_t     noc_out,
   input  wire logic              noc_out_ready
);

   logic [dma_pkg::table_entries-1:0] valid;
   dma_pkg::slot_t    read_pos;
   dma_pkg::dma_req_t read_req;
   logic              req_start;
   logic              word_valid;
   logic [31:0]       word;
   logic              word_ready;

   // descriptor table
   dma_req_table u_table (
      .clk           (clk),
      .rst           (rst),
      .ctrl_wr_en    (ctrl_wr_en),
      .ctrl_wr_pos   (ctrl_wr_pos),
      .ctrl_wr_req   (ctrl_wr_req),
      .ctrl_done_en  (ctrl_done_en),
      .ctrl_done_pos (ctrl_done_pos),
      .read_pos      (read_pos),
      .read_req      (read_req),
      .valid         (valid)
   );

   // flit generation and slot selection
   dma_noc_req_gen u_gen (
      .clk           (clk),
      .rst           (rst),
      .valid         (valid),
      .ctrl_done_en  (ctrl_done_en),
      .ctrl_done_pos (ctrl_done_pos),
      .read_pos      (read_pos),
      .read_req      (read_req),
      .req_start     (req_start),
      .word_valid    (word_valid),
      .word          (word),
      .word_ready    (word_ready),
      .noc_out_valid (noc_out_valid),
      .noc_out       (noc_out),
      .noc_out_ready (noc_out_ready)
   );

   // l2r payload fetch
   dma_local_reader u_reader (
      .clk        (clk),
      .rst        (rst),
      .req_start  (req_start),
      .read_req   (read_req),
      .lbus_req   (lbus_req),
      .lbus_addr  (lbus_addr),
      .lbus_ack   (lbus_ack),
      .lbus_data  (lbus_data),
      .word_valid (word_valid),
      .word       (word),
      .word_ready (word_ready)
   );

endmodule

`default_nettype wire

// File: dv/dma_initiator_assert.sv
// flit port protocol only, flit contents are checked by the testbench compare process
`default_nettype none

module dma_initiator_assert (
   input wire logic               clk,
   input wire logic               rst,
   input wire logic               req_start,
   input wire logic               noc_out_valid,
   input wire dma_pkg::noc_flit_t noc_out,
   input wire logic               noc_out_ready
);

   // stalled flit stays put until taken
   property flit_held;
      @(posedge clk) disable iff (rst)
         noc_out_valid && !noc_out_ready |=> noc_out_valid && $stable(noc_out);
   endproperty

   assert property (flit_held)
      else $error("noc_out dropped or changed while stalled");

   // start is a single cycle pulse
   assert property (@(posedge clk) disable iff (rst) req_start |=> !req_start)
      else $error("req_start high for more than one cycle");

   // flit port quiet once reset is applied
   assert property (@(posedge clk) rst |=> !noc_out_valid)
      else $error("noc_out_valid high right after reset");

endmodule

`default_nettype wire

// File: dv/dma_initiator_tb.sv
// one tile, local memory returns address xor 32'h5a5a_0000, back-pressure from a fixed lfsr seed
`default_nettype none

module dma_initiator_tb;

   logic               clk = 1'b0;
   logic               rst;
   logic               ctrl_wr_en;
   dma_pkg::slot_t     ctrl_wr_pos;
   dma_pkg::dma_req_t  ctrl_wr_req;
   logic               ctrl_done_en;
   dma_pkg::slot_t     ctrl_done_pos;
   logic               lbus_req;
   logic [31:0]        lbus_addr;
   logic               lbus_ack;
   logic [31:0]        lbus_data;
   logic               noc_out_valid;
   dma_pkg::noc_flit_t noc_out;
   logic               noc_out_ready;

   // expected flits per slot, and the slot order the arbiter should follow
   dma_pkg::noc_flit_t exp_q [dma_pkg::table_entries][$];
   int                 order_q[$];
   // local addresses the reader should fetch, in order
   logic [31:0]        addr_q[$];
   int                 flit_total = 0;
   int                 cycles = 0;
   logic [31:0]        lfsr = 32'h3489_ba1d;
   logic [1:0]         ack_wait;
   int                 cur_slot;
   logic               busy = 1'b0;

   dma_initiator_top dut0 (.*);

   bind dma_noc_req_gen dma_initiator_assert u_assert (
      .clk           (clk),
      .rst           (rst),
      .req_start     (req_start),
      .noc_out_valid (noc_out_valid),
      .noc_out       (noc_out),
      .noc_out_ready (noc_out_ready)
   );

   always #20 clk = ~clk;

   // galois step for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'h8020_0003;
      end
      return n;
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v[i] = lfsr[0];
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic report_failure(input string why);
      $display("%s", why);
      $display("Errors found");
      $fatal(1);
   endtask

   function automatic dma_pkg::dma_req_t make_req(input dma_pkg::dma_dir_e dir, input int rtile,
                                                  input int size, input logic [31:0] laddr,
                                                  input logic [31:0] raddr);
      dma_pkg::dma_req_t r;
      r.dir   = dir;
      r.rtile = 5'(rtile);
      r.size  = dma_pkg::size_t'(size);
      r.laddr = laddr;
      r.raddr = raddr;
      return r;
   endfunction

   // r2l is four flits and l2r adds header and address per packet
   function automatic int ref_count(input dma_pkg::dma_req_t req);
      int per_pkt;
      per_pkt = dma_pkg::packet_flits - 2;
      if (req.dir == dma_pkg::r2l) begin
         return 4;
      end
      return int'(req.size) + 2 * ((int'(req.size) + per_pkt - 1) / per_pkt);
   endfunction

   // expected flit n of a descriptor held in a given slot
   function automatic dma_pkg::noc_flit_t ref_flit(input dma_pkg::dma_req_t req, input int slot,
                                                   input int n);
      dma_pkg::noc_flit_t f;
      dma_pkg::noc_hdr_t  h;
      int per_pkt;
      int total;
      int sent;
      int chunk;
      int k;
      per_pkt  = dma_pkg::packet_flits - 2;
      total    = int'(req.size);
      h        = '0;
      h.dest   = req.rtile;
      h.pclass = dma_pkg::class_dma;
      h.src    = dma_pkg::tile_id;
      h.id     = dma_pkg::slot_t'(slot);
      h.last   = 1'b1;
      f.ftype   = dma_pkg::payload;
      f.content = '0;
      if (req.dir == dma_pkg::r2l) begin
         // header with empty size, then size, raddr, laddr
         h.ptype = dma_pkg::r2l_req;
         case (n)
            0: begin
               f.ftype   = dma_pkg::header;
               f.content = h;
            end
            1: f.content = 32'(req.size);
            2: f.content = req.raddr;
            default: begin
               f.ftype   = dma_pkg::last;
               f.content = req.laddr;
            end
         endcase
      end else begin
         // skip whole packets ahead of flit n
         sent  = 0;
         k     = n;
         chunk = (total < per_pkt) ? total : per_pkt;
         while (k >= chunk + 2) begin
            k     = k - (chunk + 2);
            sent  = sent + chunk;
            chunk = (total - sent < per_pkt) ? total - sent : per_pkt;
         end
         if (k == 0) begin
            h.ptype   = dma_pkg::l2r_req;
            h.size    = dma_pkg::size_t'(chunk);
            h.last    = (sent + chunk == total);
            f.ftype   = dma_pkg::header;
            f.content = h;
         end else if (k == 1) begin
            f.content = req.raddr + 32'(4 * sent);
         end else begin
            // memory word sent + k - 2 counted from laddr
            f.content = (req.laddr + 32'(4 * (sent + k - 2))) ^ 32'h5a5a_0000;
            if (k == chunk + 1) begin
               f.ftype = dma_pkg::last;
            end
         end
      end
      return f;
   endfunction

   function automatic int pending_flits();
      int sum;
      sum = order_q.size();
      for (int s = 0; s < dma_pkg::table_entries; s++) begin
         sum = sum + exp_q[s].size();
      end
      return sum;
   endfunction

   // serve says whether the descriptor is expected on the noc
   task automatic write_slot(input int slot, input dma_pkg::dma_req_t req, input logic serve);
      int n;
      @(posedge clk);
      ctrl_wr_en  <= 1'b1;
      ctrl_wr_pos <= dma_pkg::slot_t'(slot);
      ctrl_wr_req <= req;
      if (serve) begin
         n = ref_count(req);
         for (int k = 0; k < n; k++) begin
            exp_q[slot].push_back(ref_flit(req, slot, k));
         end
         // l2r payload is fetched word by word from laddr
         if (req.dir == dma_pkg::l2r) begin
            for (int w = 0; w < int'(req.size); w++) begin
               addr_q.push_back(req.laddr + 32'(4 * w));
            end
         end
         order_q.push_back(slot);
         flit_total = flit_total + n;
      end
      @(posedge clk);
      ctrl_wr_en <= 1'b0;
   endtask

   task automatic pulse_done(input int slot);
      @(posedge clk);
      ctrl_done_en  <= 1'b1;
      ctrl_done_pos <= dma_pkg::slot_t'(slot);
      @(posedge clk);
      ctrl_done_en <= 1'b0;
   endtask

   task automatic wait_drained();
      while (pending_flits() != 0) begin
         @(posedge clk);
      end
   endtask

   // noc sink and local memory share one lfsr
   always @(posedge clk) begin : bus_and_sink
      logic [31:0] v;
      if (rst) begin
         noc_out_ready <= 1'b0;
         lbus_ack      <= 1'b0;
         ack_wait      <= 2'd0;
      end else begin
         take_bits(1, v);
         noc_out_ready <= v[0];
         if (lbus_ack) begin
            // new wait of 0 to 3 cycles for the next read
            lbus_ack <= 1'b0;
            take_bits(2, v);
            ack_wait <= v[1:0];
         end else if (lbus_req) begin
            if (ack_wait == 2'd0) begin
               // every read fetches the next word of a served l2r descriptor
               assert (addr_q.size() != 0)
                  else report_failure("A local bus read was issued with no payload word left");
               assert (lbus_addr === addr_q[0])
                  else report_failure($sformatf("** Error lbus_addr got %h expected %h",
                                                lbus_addr, addr_q[0]));
               addr_q.delete(0);
               lbus_ack  <= 1'b1;
               lbus_data <= lbus_addr ^ 32'h5a5a_0000;
            end else begin
               ack_wait <= ack_wait - 2'd1;
            end
         end
      end
   end

   // compare each transferred flit with the head of its slot queue
   always @(posedge clk) begin : compare
      dma_pkg::noc_flit_t want;
      if (!rst && noc_out_valid && noc_out_ready) begin
         if (!busy) begin
            assert (order_q.size() != 0)
               else report_failure("A flit went out on noc_out while no request was expected");
            cur_slot = order_q.pop_front();
            busy     = 1'b1;
         end
         want = exp_q[cur_slot].pop_front();
         assert (noc_out === want)
            else report_failure($sformatf("** Error noc_out got %h expected %h", noc_out, want));
         if (exp_q[cur_slot].size() == 0) begin
            busy = 1'b0;
         end
      end
   end

   // limit grows with every expected flit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > 40 * flit_total + 500) begin
         report_failure("Timeout, the expected flits did not all arrive in time");
      end
   end

   initial begin
      rst           = 1'b1;
      ctrl_wr_en    = 1'b0;
      ctrl_wr_pos   = '0;
      ctrl_wr_req   = '0;
      ctrl_done_en  = 1'b0;
      ctrl_done_pos = '0;
      lbus_ack      = 1'b0;
      lbus_data     = '0;
      noc_out_ready = 1'b0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      // all four slots served round robin from slot 1; slot 2 spans three packets
      write_slot(1, make_req(dma_pkg::r2l, 7, 9, 32'h0000_1000, 32'h8000_0040), 1'b1);
      write_slot(2, make_req(dma_pkg::l2r, 12, 14, 32'h0000_2000, 32'h9000_0100), 1'b1);
      write_slot(3, make_req(dma_pkg::r2l, 30, 100, 32'h0000_3000, 32'ha000_0800), 1'b1);
      write_slot(0, make_req(dma_pkg::l2r, 1, 5, 32'h0000_4000, 32'hb000_0000), 1'b1);
      wait_drained();
      for (int s = 0; s < dma_pkg::table_entries; s++) begin
         pulse_done(s);
      end

      // slot 2 blocked after completion
      write_slot(2, make_req(dma_pkg::r2l, 4, 3, 32'h0000_5000, 32'hc000_0000), 1'b1);
      wait_drained();
      write_slot(2, make_req(dma_pkg::l2r, 9, 7, 32'h0000_6000, 32'hd000_0000), 1'b0);
      // no flit may leave while the slot is still open
      repeat (30) @(posedge clk);
      pulse_done(2);
      write_slot(2, make_req(dma_pkg::l2r, 9, 7, 32'h0000_6000, 32'hd000_0000), 1'b1);
      wait_drained();
      repeat (5) @(posedge clk);

      if (pending_flits() == 0) begin
         $display("No errors");
      end else begin
         report_failure("Expected flits were still pending at the end of the run");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
source/dma_pkg.sv
source/dma_req_table.sv
source/dma_rr_arb.sv
source/dma_noc_req_gen.sv
source/dma_local_reader.sv
source/dma_initiator_top.sv
dv/dma_initiator_assert.sv
dv/dma_initiator_tb.sv

// File: Makefile
# Verilator build and run of the DMA initiator testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass only if the log reports no errors"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module dma_initiator_tb --Mdir obj_dir -o dma_sim
	-./obj_dir/dma_sim > sim.log 2>&1
	@cat sim.log
	@grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
